// File: psl_buffer_bridge.f
psl_buffer_pkg.sv
entry_queue.sv
write_half_splitter.sv
write_tag_tracker.sv
response_release.sv
read_half_issue.sv
read_return_align.sv
psl_buffer_top.sv
tb_psl_buffer_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --top-module tb_psl_buffer_top -f psl_buffer_bridge.f \
  -o tb_psl_buffer_top

output="$(./obj_dir/tb_psl_buffer_top)"
echo "$output"

if grep -q -x "ALL CHECKS PASSED" <<< "$output"; then
  exit 0
else
  exit 1
fi

// File: tb_psl_buffer_top.sv
`timescale 1ns/1ps

module tb_psl_buffer_top
  import psl_buffer_pkg::*;
();

  localparam int K_IDLE      = 0;
  localparam int K_WRITE     = 1;
  localparam int K_READ      = 2;
  localparam int K_RESP      = 3;
  localparam int NUM_ROWS    = 20;
  localparam int NUM_PASSES  = 2;
  localparam int CYCLE_LIMIT = NUM_PASSES * NUM_ROWS * 40 + 200;

  logic      ha_pclock;
  logic      rst_n;
  logic      host_bw_valid;
  tag_t      host_bw_tag;
  line_t     host_bw_data;
  logic      host_br_valid;
  tag_t      host_br_tag;
  logic      host_r_valid;
  tag_t      host_r_tag;
  response_t host_r_response;
  credits_t  host_r_credits;
  logic      host_br_done_valid;
  tag_t      host_br_done_tag;
  line_t     host_br_done_data;
  logic      afu_bw_valid;
  tag_t      afu_bw_tag;
  logic      afu_bw_ad;
  half_t     afu_bw_data;
  logic      afu_br_valid;
  tag_t      afu_br_tag;
  logic      afu_br_ad;
  brlat_t    afu_br_lat;
  half_t     afu_br_data;
  logic      afu_r_valid;
  tag_t      afu_r_tag;
  response_t afu_r_response;
  credits_t  afu_r_credits;

  // Stimulus table, one entry per row
  int        row_kind [NUM_ROWS];
  tag_t      row_tag [NUM_ROWS];
  response_t row_resp [NUM_ROWS];
  credits_t  row_credits [NUM_ROWS];
  int        row_idle [NUM_ROWS];
  int        row_count;

  // Expected results per path
  tag_t      wr_exp_tag [$];
  line_t     wr_exp_line [$];
  logic      wr_phase;
  int        wr_pushed [256];
  int        wr_delivered [256];
  int        wr_done_cycle [256];
  tag_t      rsp_exp_tag [$];
  response_t rsp_exp_resp [$];
  credits_t  rsp_exp_credits [$];
  int        rsp_exp_need [$];
  tag_t      rd_exp_tag [$];
  int        rd_done_cycle [$];
  logic      br_first_seen;

  // Accelerator read model, slots indexed by cycle
  logic      sched_valid [32];
  half_t     sched_data [32];

  int          cyc;
  int          cycle_count = 0;
  logic [31:0] rng_state;
  int          wr_errors;
  int          rsp_errors;
  int          rd_errors;
  int          seq_errors;

  psl_buffer_top psl_buffer_top_inst (
    .ha_pclock          (ha_pclock),
    .rst_n              (rst_n),
    .host_bw_valid      (host_bw_valid),
    .host_bw_tag        (host_bw_tag),
    .host_bw_data       (host_bw_data),
    .host_br_valid      (host_br_valid),
    .host_br_tag        (host_br_tag),
    .host_r_valid       (host_r_valid),
    .host_r_tag         (host_r_tag),
    .host_r_response    (host_r_response),
    .host_r_credits     (host_r_credits),
    .host_br_done_valid (host_br_done_valid),
    .host_br_done_tag   (host_br_done_tag),
    .host_br_done_data  (host_br_done_data),
    .afu_bw_valid       (afu_bw_valid),
    .afu_bw_tag         (afu_bw_tag),
    .afu_bw_ad          (afu_bw_ad),
    .afu_bw_data        (afu_bw_data),
    .afu_br_valid       (afu_br_valid),
    .afu_br_tag         (afu_br_tag),
    .afu_br_ad          (afu_br_ad),
    .afu_br_lat         (afu_br_lat),
    .afu_br_data        (afu_br_data),
    .afu_r_valid        (afu_r_valid),
    .afu_r_tag          (afu_r_tag),
    .afu_r_response     (afu_r_response),
    .afu_r_credits      (afu_r_credits)
  );

  always #10 ha_pclock = ~ha_pclock;

  always @(posedge ha_pclock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Accelerator return data for one half request
  function automatic half_t half_pattern(input tag_t tag, input logic ad);
    return {32{tag, ~tag[6:0], ad}};
  endfunction

  task automatic random_line(output line_t line);
    for (int i = 0; i < LINE_W / 32; i++) begin
      rng_state = xorshift32(rng_state);
      line[i*32 +: 32] = rng_state;
    end
  endtask

  task automatic add_row(input int kind, input tag_t tag, input response_t resp,
                         input credits_t credits, input int idle);
    row_kind[row_count]    = kind;
    row_tag[row_count]     = tag;
    row_resp[row_count]    = resp;
    row_credits[row_count] = credits;
    row_idle[row_count]    = idle;
    row_count++;
  endtask

  task automatic fill_table();
    row_count = 0;
    // Response held behind two lines, clear tag waits behind it
    add_row(K_WRITE, 8'h11, 8'h00, 9'h000, 0);
    add_row(K_WRITE, 8'h11, 8'h00, 9'h000, 0);
    add_row(K_RESP,  8'h11, 8'h01, 9'h005, 0);
    add_row(K_RESP,  8'h22, 8'h02, 9'h1ff, 0);
    add_row(K_READ,  8'h30, 8'h00, 9'h000, 0);
    add_row(K_READ,  8'h31, 8'h00, 9'h000, 0);
    add_row(K_READ,  8'h32, 8'h00, 9'h000, 2);
    add_row(K_WRITE, 8'h44, 8'h00, 9'h000, 0);
    add_row(K_RESP,  8'h44, 8'h80, 9'h100, 3);
    add_row(K_IDLE,  8'h00, 8'h00, 9'h000, 8);
    add_row(K_RESP,  8'h55, 8'h7f, 9'h00a, 0);
    add_row(K_WRITE, 8'h66, 8'h00, 9'h000, 0);
    add_row(K_WRITE, 8'h77, 8'h00, 9'h000, 0);
    add_row(K_WRITE, 8'h66, 8'h00, 9'h000, 0);
    add_row(K_RESP,  8'h77, 8'h33, 9'h012, 0);
    add_row(K_RESP,  8'h66, 8'h34, 9'h013, 0);
    add_row(K_READ,  8'ha0, 8'h00, 9'h000, 0);
    add_row(K_WRITE, 8'ha0, 8'h00, 9'h000, 0);
    add_row(K_READ,  8'ha1, 8'h00, 9'h000, 5);
    add_row(K_RESP,  8'hff, 8'hee, 9'h1aa, 10);
  endtask

  task automatic check_write_half(input tag_t exp_tag, input logic exp_ad,
                                  input half_t exp_data);
    if (afu_bw_tag !== exp_tag || afu_bw_ad !== exp_ad || afu_bw_data !== exp_data) begin
      wr_errors++;
      $display("MISMATCH at %0t: write half tag %h ad %b, expected tag %h ad %b, data %s",
               $time, afu_bw_tag, afu_bw_ad, exp_tag, exp_ad,
               (afu_bw_data === exp_data) ? "ok" : "differs");
    end
  endtask

  task automatic check_response(input tag_t exp_tag, input response_t exp_resp,
                                input credits_t exp_credits);
    if (afu_r_tag !== exp_tag || afu_r_response !== exp_resp ||
        afu_r_credits !== exp_credits) begin
      rsp_errors++;
      $display("MISMATCH at %0t: response %h/%h/%h, expected %h/%h/%h", $time,
               afu_r_tag, afu_r_response, afu_r_credits, exp_tag, exp_resp, exp_credits);
    end
  endtask

  task automatic check_read_line(input tag_t exp_tag, input line_t exp_data);
    if (host_br_done_tag !== exp_tag || host_br_done_data !== exp_data) begin
      rd_errors++;
      $display("MISMATCH at %0t: read line tag %h, expected tag %h, data %s", $time,
               host_br_done_tag, exp_tag, (host_br_done_data === exp_data) ? "ok" : "differs");
    end
  endtask

  task automatic observe_outputs();
    tag_t t;
    int   dc;
    int   need;
    // Responses before this cycle's write delivery is counted
    if (afu_r_valid) begin
      if (rsp_exp_tag.size() == 0) begin
        seq_errors++;
        $display("Unexpected response with tag %h at %0t", afu_r_tag, $time);
      end else begin
        t    = rsp_exp_tag.pop_front();
        need = rsp_exp_need.pop_front();
        check_response(t, rsp_exp_resp.pop_front(), rsp_exp_credits.pop_front());
        // Release comes a cycle after the last line, then the delay line
        if (wr_delivered[t] < need ||
            (need > 0 && cyc <= wr_done_cycle[t] + RESP_DELAY)) begin
          seq_errors++;
          $display("Response for tag %h left before its write lines at %0t", t, $time);
        end
      end
    end
    if (afu_bw_valid) begin
      if (wr_exp_tag.size() == 0) begin
        seq_errors++;
        $display("Unexpected write half with tag %h at %0t", afu_bw_tag, $time);
      end else if (!wr_phase) begin
        check_write_half(wr_exp_tag[0], 1'b0, wr_exp_line[0][LINE_W-1:HALF_W]);
        wr_phase = 1'b1;
      end else begin
        check_write_half(wr_exp_tag[0], 1'b1, wr_exp_line[0][HALF_W-1:0]);
        wr_delivered[wr_exp_tag[0]]++;
        wr_done_cycle[wr_exp_tag[0]] = cyc;
        void'(wr_exp_tag.pop_front());
        void'(wr_exp_line.pop_front());
        wr_phase = 1'b0;
      end
    end else if (wr_phase) begin
      seq_errors++;
      $display("Second write half of tag %h did not follow at %0t", wr_exp_tag[0], $time);
      void'(wr_exp_tag.pop_front());
      void'(wr_exp_line.pop_front());
      wr_phase = 1'b0;
    end
    // Half requests come in pairs, address 0 then 1
    if (afu_br_valid) begin
      if (afu_br_ad !== br_first_seen) begin
        seq_errors++;
        $display("Read half request out of order at %0t", $time);
      end
      sched_valid[(cyc + int'(afu_br_lat)) % 32] = 1'b1;
      sched_data[(cyc + int'(afu_br_lat)) % 32]  = half_pattern(afu_br_tag, afu_br_ad);
      if (afu_br_ad) begin
        rd_done_cycle.push_back(cyc + int'(afu_br_lat) + 1);
      end
      br_first_seen = !afu_br_ad;
    end else begin
      if (br_first_seen) begin
        seq_errors++;
        $display("Second read half request missing at %0t", $time);
      end
      br_first_seen = 1'b0;
    end
    if (host_br_done_valid) begin
      if (rd_exp_tag.size() == 0 || rd_done_cycle.size() == 0) begin
        seq_errors++;
        $display("Unexpected read line with tag %h at %0t", host_br_done_tag, $time);
      end else begin
        t  = rd_exp_tag.pop_front();
        dc = rd_done_cycle.pop_front();
        if (dc != cyc) begin
          seq_errors++;
          $display("Read line for tag %h came at cycle %0d, due at cycle %0d", t, cyc, dc);
        end
        check_read_line(t, {half_pattern(t, 1'b0), half_pattern(t, 1'b1)});
      end
    end else if (rd_done_cycle.size() > 0 && rd_done_cycle[0] == cyc) begin
      seq_errors++;
      $display("Read line missing at cycle %0d", cyc);
      void'(rd_done_cycle.pop_front());
      if (rd_exp_tag.size() > 0) begin
        void'(rd_exp_tag.pop_front());
      end
    end
  endtask

  task automatic drive_read_data();
    if (sched_valid[cyc % 32]) begin
      afu_br_data = sched_data[cyc % 32];
      sched_valid[cyc % 32] = 1'b0;
    end else begin
      afu_br_data = '1;
    end
  endtask

  // Outputs are stable at the falling edge, inputs change right after
  task automatic next_cycle();
    @(negedge ha_pclock);
    cyc++;
    if (rst_n) begin
      observe_outputs();
    end
    drive_read_data();
  endtask

  task automatic idle_inputs();
    host_bw_valid   = 1'b0;
    host_bw_tag     = '0;
    host_bw_data    = '0;
    host_br_valid   = 1'b0;
    host_br_tag     = '0;
    host_r_valid    = 1'b0;
    host_r_tag      = '0;
    host_r_response = '0;
    host_r_credits  = '0;
  endtask

  task automatic clear_model();
    wr_phase      = 1'b0;
    br_first_seen = 1'b0;
    for (int i = 0; i < 32; i++) begin
      sched_valid[i] = 1'b0;
    end
    for (int i = 0; i < 256; i++) begin
      wr_pushed[i]     = 0;
      wr_delivered[i]  = 0;
      wr_done_cycle[i] = 0;
    end
    wr_exp_tag.delete();
    wr_exp_line.delete();
    rsp_exp_tag.delete();
    rsp_exp_resp.delete();
    rsp_exp_credits.delete();
    rsp_exp_need.delete();
    rd_exp_tag.delete();
    rd_done_cycle.delete();
  endtask

  task automatic reset_dut(input brlat_t lat);
    rst_n = 1'b0;
    idle_inputs();
    afu_br_lat = lat;
    clear_model();
    repeat (5) next_cycle();
    rst_n = 1'b1;
  endtask

  task automatic apply_row(input int i);
    line_t line;
    case (row_kind[i])
      K_WRITE: begin
        random_line(line);
        host_bw_valid = 1'b1;
        host_bw_tag   = row_tag[i];
        host_bw_data  = line;
        wr_exp_tag.push_back(row_tag[i]);
        wr_exp_line.push_back(line);
        wr_pushed[row_tag[i]]++;
      end
      K_READ: begin
        host_br_valid = 1'b1;
        host_br_tag   = row_tag[i];
        rd_exp_tag.push_back(row_tag[i]);
      end
      K_RESP: begin
        host_r_valid    = 1'b1;
        host_r_tag      = row_tag[i];
        host_r_response = row_resp[i];
        host_r_credits  = row_credits[i];
        rsp_exp_tag.push_back(row_tag[i]);
        rsp_exp_resp.push_back(row_resp[i]);
        rsp_exp_credits.push_back(row_credits[i]);
        rsp_exp_need.push_back(wr_pushed[row_tag[i]]);
      end
      default: begin
      end
    endcase
    next_cycle();
    idle_inputs();
    repeat (row_idle[i]) next_cycle();
  endtask

  task automatic run_table();
    // Quiet outputs before any stimulus
    repeat (4) next_cycle();
    for (int i = 0; i < row_count; i++) begin
      apply_row(i);
    end
    while (wr_exp_tag.size() > 0 || rsp_exp_tag.size() > 0 || rd_exp_tag.size() > 0) begin
      next_cycle();
    end
    repeat (10) next_cycle();
  endtask

  initial begin
    ha_pclock   = 1'b0;
    rst_n       = 1'b0;
    afu_br_lat  = brlat_t'(BRLAT_MIN);
    afu_br_data = '0;
    idle_inputs();
    rng_state  = 32'd91706;
    cyc        = 0;
    wr_errors  = 0;
    rsp_errors = 0;
    rd_errors  = 0;
    seq_errors = 0;
    fill_table();
    reset_dut(brlat_t'(BRLAT_MIN));
    run_table();
    reset_dut(brlat_t'(4));
    run_table();
    $display("Error counts: write %0d, response %0d, read %0d, sequence %0d",
             wr_errors, rsp_errors, rd_errors, seq_errors);
    if (wr_errors + rsp_errors + rd_errors + seq_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: psl_buffer_top.sv
`timescale 1ns/1ps

module psl_buffer_top
  import psl_buffer_pkg::*;
(
  input  logic      ha_pclock,
  input  logic      rst_n,

  // Host side
  input  logic      host_bw_valid,
  input  tag_t      host_bw_tag,
  input  line_t     host_bw_data,
  input  logic      host_br_valid,
  input  tag_t      host_br_tag,
  input  logic      host_r_valid,
  input  tag_t      host_r_tag,
  input  response_t host_r_response,
  input  credits_t  host_r_credits,
  output logic      host_br_done_valid,
  output tag_t      host_br_done_tag,
  output line_t     host_br_done_data,

  // Accelerator side
  output logic      afu_bw_valid,
  output tag_t      afu_bw_tag,
  output logic      afu_bw_ad,
  output half_t     afu_bw_data,
  output logic      afu_br_valid,
  output tag_t      afu_br_tag,
  output logic      afu_br_ad,
  input  brlat_t    afu_br_lat,
  input  half_t     afu_br_data,
  output logic      afu_r_valid,
  output tag_t      afu_r_tag,
  output response_t afu_r_response,
  output credits_t  afu_r_credits
);

  wr_entry_t  wr_in;
  wr_entry_t  wr_head;
  logic       wr_empty;
  logic       wr_pop;
  logic       line_done;

  rsp_entry_t rsp_in;
  rsp_entry_t rsp_head;
  logic       rsp_empty;
  logic       rsp_pop;
  tag_t       query_tag;
  logic       query_clear;

  tag_t       rd_head;
  logic       rd_empty;
  logic       rd_pop;

  assign wr_in  = '{tag: host_bw_tag, line: host_bw_data};
  assign rsp_in = '{tag: host_r_tag, response: host_r_response, credits: host_r_credits};

  // Write path
  entry_queue #(.payload_t(wr_entry_t)) wr_queue_inst (
    .ha_pclock  (ha_pclock),
    .rst_n      (rst_n),
    .push       (host_bw_valid),
    .pop        (wr_pop),
    .wr_payload (wr_in),
    .head       (wr_head),
    .empty      (wr_empty)
  );

  write_half_splitter write_half_splitter_inst (
    .ha_pclock    (ha_pclock),
    .rst_n        (rst_n),
    .empty        (wr_empty),
    .head         (wr_head),
    .pop          (wr_pop),
    .afu_bw_valid (afu_bw_valid),
    .afu_bw_tag   (afu_bw_tag),
    .afu_bw_ad    (afu_bw_ad),
    .afu_bw_data  (afu_bw_data),
    .line_done    (line_done)
  );

  write_tag_tracker write_tag_tracker_inst (
    .ha_pclock     (ha_pclock),
    .rst_n         (rst_n),
    .host_bw_valid (host_bw_valid),
    .host_bw_tag   (host_bw_tag),
    .line_done     (line_done),
    .done_tag      (afu_bw_tag),
    .query_tag     (query_tag),
    .query_clear   (query_clear)
  );

  // Response path, ordered behind pending writes
  entry_queue #(.payload_t(rsp_entry_t)) rsp_queue_inst (
    .ha_pclock  (ha_pclock),
    .rst_n      (rst_n),
    .push       (host_r_valid),
    .pop        (rsp_pop),
    .wr_payload (rsp_in),
    .head       (rsp_head),
    .empty      (rsp_empty)
  );

  response_release response_release_inst (
    .ha_pclock      (ha_pclock),
    .rst_n          (rst_n),
    .empty          (rsp_empty),
    .head           (rsp_head),
    .query_clear    (query_clear),
    .pop            (rsp_pop),
    .query_tag      (query_tag),
    .afu_r_valid    (afu_r_valid),
    .afu_r_tag      (afu_r_tag),
    .afu_r_response (afu_r_response),
    .afu_r_credits  (afu_r_credits)
  );

  // Read path
  entry_queue #(.payload_t(tag_t)) rd_queue_inst (
    .ha_pclock  (ha_pclock),
    .rst_n      (rst_n),
    .push       (host_br_valid),
    .pop        (rd_pop),
    .wr_payload (host_br_tag),
    .head       (rd_head),
    .empty      (rd_empty)
  );

  read_half_issue read_half_issue_inst (
    .ha_pclock    (ha_pclock),
    .rst_n        (rst_n),
    .empty        (rd_empty),
    .head         (rd_head),
    .pop          (rd_pop),
    .afu_br_valid (afu_br_valid),
    .afu_br_tag   (afu_br_tag),
    .afu_br_ad    (afu_br_ad)
  );

  read_return_align read_return_align_inst (
    .ha_pclock          (ha_pclock),
    .rst_n              (rst_n),
    .afu_br_valid       (afu_br_valid),
    .afu_br_tag         (afu_br_tag),
    .afu_br_ad          (afu_br_ad),
    .afu_br_lat         (afu_br_lat),
    .afu_br_data        (afu_br_data),
    .host_br_done_valid (host_br_done_valid),
    .host_br_done_tag   (host_br_done_tag),
    .host_br_done_data  (host_br_done_data)
  );

endmodule

// File: read_return_align.sv
`timescale 1ns/1ps

module read_return_align
  import psl_buffer_pkg::*;
(
  input  logic   ha_pclock,
  input  logic   rst_n,
  input  logic   afu_br_valid,
  input  tag_t   afu_br_tag,
  input  logic   afu_br_ad,
  input  brlat_t afu_br_lat,
  input  half_t  afu_br_data,
  output logic   host_br_done_valid,
  output tag_t   host_br_done_tag,
  output line_t  host_br_done_data
);

  logic [BRLAT_MAX:0] mark_line;
  logic [BRLAT_MAX:0] mark_next;
  tag_t               tag_line [BRLAT_MAX+1];
  logic               second_req;
  half_t              last_half;
  half_t              prev_half;

  assign second_req = afu_br_valid && afu_br_ad;

  // Marker enters at the latency slot and reaches slot 0 one cycle
  // after the second half is on the bus
  always_comb begin
    mark_next = {1'b0, mark_line[BRLAT_MAX:1]};
    if (second_req) begin
      mark_next[afu_br_lat] = 1'b1;
    end
  end

  always_ff @(posedge ha_pclock) begin
    if (!rst_n) begin
      mark_line <= '0;
    end else begin
      mark_line <= mark_next;
    end
  end

  always_ff @(posedge ha_pclock) begin
    for (int i = 0; i < BRLAT_MAX; i++) begin
      tag_line[i] <= tag_line[i+1];
    end
    if (second_req) begin
      tag_line[afu_br_lat] <= afu_br_tag;
    end
  end

  // Return data is sampled every cycle
  always_ff @(posedge ha_pclock) begin
    last_half <= afu_br_data;
    prev_half <= last_half;
  end

  assign host_br_done_valid = mark_line[0];
  assign host_br_done_tag   = tag_line[0];

  // First returned half lands in the upper bits
  assign host_br_done_data = {prev_half, last_half};

endmodule

// File: read_half_issue.sv
`timescale 1ns/1ps

module read_half_issue
  import psl_buffer_pkg::*;
(
  input  logic ha_pclock,
  input  logic rst_n,
  input  logic empty,
  input  tag_t head,
  output logic pop,
  output logic afu_br_valid,
  output tag_t afu_br_tag,
  output logic afu_br_ad
);

  tag_t tag_q;
  logic busy_q;
  logic half_q;

  // Back to back requests when the queue keeps up
  assign pop = !empty && (!busy_q || half_q);

  always_ff @(posedge ha_pclock) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      half_q <= 1'b0;
    end else if (pop) begin
      busy_q <= 1'b1;
      half_q <= 1'b0;
    end else begin
      busy_q <= busy_q && !half_q;
      half_q <= busy_q && !half_q;
    end
  end

  always_ff @(posedge ha_pclock) begin
    if (pop) begin
      tag_q <= head;
    end
  end

  assign afu_br_valid = busy_q;
  assign afu_br_tag   = tag_q;
  assign afu_br_ad    = half_q;

endmodule

// File: response_release.sv
`timescale 1ns/1ps

module response_release
  import psl_buffer_pkg::*;
(
  input  logic       ha_pclock,
  input  logic       rst_n,
  input  logic       empty,
  input  rsp_entry_t head,
  input  logic       query_clear,
  output logic       pop,
  output tag_t       query_tag,
  output logic       afu_r_valid,
  output tag_t       afu_r_tag,
  output response_t  afu_r_response,
  output credits_t   afu_r_credits
);

  logic [RESP_DELAY-1:0] valid_line;
  rsp_entry_t            entry_line [RESP_DELAY];

  // Head waits until no write line of its tag is outstanding
  assign query_tag = head.tag;
  assign pop       = !empty && query_clear;

  always_ff @(posedge ha_pclock) begin
    if (!rst_n) begin
      valid_line <= '0;
    end else begin
      valid_line <= {valid_line[RESP_DELAY-2:0], pop};
    end
  end

  // Payload delay line, stage 0 loads at the pop
  always_ff @(posedge ha_pclock) begin
    entry_line[0] <= head;
    for (int i = 1; i < RESP_DELAY; i++) begin
      entry_line[i] <= entry_line[i-1];
    end
  end

  assign afu_r_valid    = valid_line[RESP_DELAY-1];
  assign afu_r_tag      = entry_line[RESP_DELAY-1].tag;
  assign afu_r_response = entry_line[RESP_DELAY-1].response;
  assign afu_r_credits  = entry_line[RESP_DELAY-1].credits;

endmodule

// File: write_tag_tracker.sv
`timescale 1ns/1ps

module write_tag_tracker
  import psl_buffer_pkg::*;
(
  input  logic ha_pclock,
  input  logic rst_n,
  input  logic host_bw_valid,
  input  tag_t host_bw_tag,
  input  logic line_done,
  input  tag_t done_tag,
  input  tag_t query_tag,
  output logic query_clear
);

  pending_t pending [2**TAG_W];

  logic same_tag;

  // Arrival and delivery of one tag in the same cycle cancel out
  assign same_tag = host_bw_valid && line_done && (host_bw_tag == done_tag);

  always_ff @(posedge ha_pclock) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**TAG_W; i++) begin
        pending[i] <= '0;
      end
    end else begin
      if (host_bw_valid && !same_tag) begin
        pending[host_bw_tag] <= pending[host_bw_tag] + 1'b1;
      end
      if (line_done && !same_tag) begin
        pending[done_tag] <= pending[done_tag] - 1'b1;
      end
    end
  end

  assign query_clear = (pending[query_tag] == '0);

endmodule

// File: write_half_splitter.sv
`timescale 1ns/1ps

module write_half_splitter
  import psl_buffer_pkg::*;
(
  input  logic      ha_pclock,
  input  logic      rst_n,
  input  logic      empty,
  input  wr_entry_t head,
  output logic      pop,
  output logic      afu_bw_valid,
  output tag_t      afu_bw_tag,
  output logic      afu_bw_ad,
  output half_t     afu_bw_data,
  output logic      line_done
);

  wr_entry_t line_q;
  logic      busy_q;
  logic      half_q;

  // Next line may be taken while the lower half goes out
  assign pop = !empty && (!busy_q || half_q);

  always_ff @(posedge ha_pclock) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      half_q <= 1'b0;
    end else if (pop) begin
      busy_q <= 1'b1;
      half_q <= 1'b0;
    end else if (busy_q && !half_q) begin
      half_q <= 1'b1;
    end else begin
      busy_q <= 1'b0;
      half_q <= 1'b0;
    end
  end

  always_ff @(posedge ha_pclock) begin
    if (pop) begin
      line_q <= head;
    end
  end

  assign afu_bw_valid = busy_q;
  assign afu_bw_tag   = line_q.tag;
  assign afu_bw_ad    = half_q;

  // Upper half first, then lower half
  assign afu_bw_data = half_q ? line_q.line[HALF_W-1:0]
                              : line_q.line[LINE_W-1:HALF_W];

  // Line fully delivered in the lower half cycle
  assign line_done = busy_q && half_q;

endmodule

// File: entry_queue.sv
`timescale 1ns/1ps

module entry_queue
  import psl_buffer_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  logic     ha_pclock,
  input  logic     rst_n,
  input  logic     push,
  input  logic     pop,
  input  payload_t wr_payload,
  output payload_t head,
  output logic     empty
);

  payload_t mem [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  // Pointers wrap naturally at the queue depth
  always_ff @(posedge ha_pclock) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge ha_pclock) begin
    if (push) begin
      mem[wr_ptr] <= wr_payload;
    end
  end

  assign head  = mem[rd_ptr];
  assign empty = (wr_ptr == rd_ptr);

endmodule

// File: psl_buffer_pkg.sv
package psl_buffer_pkg;

  // Interface widths
  localparam int TAG_W  = 8;
  localparam int LINE_W = 1024;
  localparam int HALF_W = 512;

  // Host queue sizing, one pointer bit per power of two
  localparam int QUEUE_DEPTH = 64;
  localparam int PTR_W       = 6;

  // Legal accelerator read latency
  localparam int BRLAT_MIN = 1;
  localparam int BRLAT_MAX = 15;

  // Cycles from response release to the accelerator
  localparam int RESP_DELAY = 3;

  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [HALF_W-1:0] half_t;
  typedef logic [7:0]        response_t;
  typedef logic [8:0]        credits_t;

  // At most three lines in flight per tag
  typedef logic [1:0] pending_t;

  typedef logic [3:0] brlat_t;

  // Queued host write line
  typedef struct packed {
    tag_t  tag;
    line_t line;
  } wr_entry_t;

  // Queued host response
  typedef struct packed {
    tag_t      tag;
    response_t response;
    credits_t  credits;
  } rsp_entry_t;

endpackage
